// ==== hw/lsu_settings.svh ====
// Sizing of the load/store unit and its data memory.
// Byte lane logic assumes a 32-bit data path and a power-of-two depth.
// LSU_MEM_AW must be log2 of LSU_MEM_WORDS.
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Width of data and byte addresses
`define LSU_DATA_W 32

// Bus transactions that may be outstanding at once
`define LSU_DEPTH 2

// Data memory size in words and the width of the word index
`define LSU_MEM_WORDS 256
`define LSU_MEM_AW 8

`endif

// ==== hw/lsu_pkg.sv ====
// Types shared by the request and response sides of the LSU.
// The record in lsu_info_t travels from acceptance to the last rvalid.
package lsu_pkg;

  //////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////

  // Memory operation carried by one instruction
  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  // Access size, the value 3 is not a legal size
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  //////////////////////////////////////////////////
  // Request side FSM
  //////////////////////////////////////////////////

  // FIRST issues the only or the lower half, SECOND the upper half
  typedef enum logic [1:0] {
    ISSUE_IDLE   = 2'd0,
    ISSUE_FIRST  = 2'd1,
    ISSUE_SECOND = 2'd2
  } lsu_issue_e;

  // What the response side needs to rebuild the result of one instruction
  typedef struct packed {
    lsu_op_e    op;
    lsu_size_e  size;
    logic       is_signed;
    logic [1:0] off;
    logic       split;
  } lsu_info_t;

endpackage

// ==== hw/obi_data_if.sv ====
// OBI-style data bus with word-aligned addresses.
// Payload must hold from req until gnt, and one rvalid follows each transfer in order.
`timescale 1ns/1ps
`include "lsu_settings.svh"

interface obi_data_if;

  // Address phase, driven by the manager
  logic                      req;
  logic [`LSU_DATA_W-1:0]    addr;
  logic                      we;
  logic [`LSU_DATA_W/8-1:0]  be;
  logic [`LSU_DATA_W-1:0]    wdata;

  // Grant and response phase, driven by the subordinate
  logic                      gnt;
  logic                      rvalid;
  logic [`LSU_DATA_W-1:0]    rdata;

  // The LSU request side issues transfers
  modport manager (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  // The memory accepts transfers and answers them
  modport subordinate (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

  // Observers see every signal and drive none
  modport monitor (
    input req, addr, we, be, wdata,
    input gnt, rvalid, rdata
  );

endinterface

// ==== hw/lsu_request.sv ====
// Request side of the LSU: accepts instructions and issues bus transfers.
// A boundary crossing access is issued as two word transfers, lower word first.
// The transfer counter limits outstanding transfers to LSU_DEPTH.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_request
  import lsu_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_i,
  output logic                     ready_o,
  input  logic                     op_i,
  input  logic [1:0]               size_i,
  input  logic                     signed_i,
  input  logic [`LSU_DATA_W-1:0]   addr_i,
  input  logic [`LSU_DATA_W-1:0]   wdata_i,
  input  logic                     resp_done_i,
  output logic                     busy_o,
  output logic                     info_push_o,
  output lsu_info_t                info_o,
  obi_data_if.manager              bus
);

  localparam logic [1:0] DEPTH_C = 2'(`LSU_DEPTH);

  lsu_issue_e                  state_q;
  lsu_issue_e                  state_d;
  logic [1:0]                  cnt_q;
  logic                        live_q;
  logic                        accept;
  logic                        trans;
  logic                        count_up;
  logic                        count_down;
  logic                        split_in;

  // Latched instruction payload
  lsu_op_e                     op_q;
  lsu_size_e                   size_q;
  logic [1:0]                  off_q;
  logic                        split_q;
  logic [`LSU_DATA_W-3:0]      word_q;
  logic [`LSU_DATA_W-1:0]      wdata_q;

  // Lane-shifted byte enables and write data, low half then high half
  logic [3:0]                  base_be;
  logic [7:0]                  be_wide;
  logic [2*`LSU_DATA_W-1:0]    wdata_wide;

  //////////////////////////////////////////////////
  // Instruction acceptance
  //////////////////////////////////////////////////

  // A full counter still admits an instruction in the cycle a completion retires
  assign ready_o = live_q && (state_q == ISSUE_IDLE) && ((cnt_q != DEPTH_C) || resp_done_i);
  assign accept  = valid_i && ready_o;

  // A halfword at offset 3 or any unaligned word spills into the next word
  always_comb begin
    case (lsu_size_e'(size_i))
      SIZE_HALF: split_in = (addr_i[1:0] == 2'b11);
      SIZE_WORD: split_in = (addr_i[1:0] != 2'b00);
      default:   split_in = 1'b0;
    endcase
  end

  // The response side records every accepted instruction
  assign info_push_o      = accept;
  assign info_o.op        = lsu_op_e'(op_i);
  assign info_o.size      = lsu_size_e'(size_i);
  assign info_o.is_signed = signed_i;
  assign info_o.off       = addr_i[1:0];
  assign info_o.split     = split_in;

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= lsu_op_e'(op_i);
      size_q  <= lsu_size_e'(size_i);
      off_q   <= addr_i[1:0];
      split_q <= split_in;
      word_q  <= addr_i[`LSU_DATA_W-1:2];
      wdata_q <= wdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Issue FSM and bus drive
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ISSUE_IDLE:   if (accept) state_d = ISSUE_FIRST;
      ISSUE_FIRST:  if (trans) state_d = split_q ? ISSUE_SECOND : ISSUE_IDLE;
      ISSUE_SECOND: if (trans) state_d = ISSUE_IDLE;
      default:      state_d = ISSUE_IDLE;
    endcase
  end

  // Instruction side stays closed until the first clock edge after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ISSUE_IDLE;
      live_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      live_q  <= 1'b1;
    end
  end

  always_comb begin
    case (size_q)
      SIZE_BYTE: base_be = 4'b0001;
      SIZE_HALF: base_be = 4'b0011;
      default:   base_be = 4'b1111;
    endcase
  end

  // Bytes that shift past lane 3 belong to the second word
  assign be_wide    = {4'b0000, base_be} << off_q;
  assign wdata_wide = {{`LSU_DATA_W{1'b0}}, wdata_q} << {off_q, 3'b000};

  // A free counter slot never disappears while req waits, so req stays up until gnt
  assign bus.req   = (state_q != ISSUE_IDLE) && ((cnt_q != DEPTH_C) || resp_done_i);
  assign bus.we    = (op_q == LSU_STORE);
  assign bus.addr  = (state_q == ISSUE_SECOND) ? {word_q + 1'b1, 2'b00} : {word_q, 2'b00};
  assign bus.be    = (state_q == ISSUE_SECOND) ? be_wide[7:4] : be_wide[3:0];
  assign bus.wdata = (state_q == ISSUE_SECOND) ? wdata_wide[2*`LSU_DATA_W-1:`LSU_DATA_W]
                                               : wdata_wide[`LSU_DATA_W-1:0];

  //////////////////////////////////////////////////
  // Outstanding transfer counter
  //////////////////////////////////////////////////

  assign trans      = bus.req && bus.gnt;
  assign count_up   = trans;
  assign count_down = resp_done_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else begin
      case ({count_up, count_down})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign busy_o = (cnt_q != 2'd0);

endmodule

// ==== hw/lsu_response.sv ====
// Response side of the LSU: rebuilds load results from bus responses.
// Relies on the request side to push at most LSU_DEPTH records ahead of their rvalids.
// Stores complete with result data 0.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_response
  import lsu_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     info_push_i,
  input  lsu_info_t                info_i,
  obi_data_if.monitor              bus,
  output logic                     resp_done_o,
  output logic                     result_valid_o,
  output logic [`LSU_DATA_W-1:0]   result_rdata_o
);

  localparam int PTR_W = (`LSU_DEPTH > 1) ? $clog2(`LSU_DEPTH) : 1;

  // Pending instruction records, oldest at rd_ptr_q
  lsu_info_t                   fifo_q [`LSU_DEPTH];
  logic [PTR_W-1:0]            wr_ptr_q;
  logic [PTR_W-1:0]            rd_ptr_q;
  lsu_info_t                   head;

  logic                        half_q;
  logic [`LSU_DATA_W-1:0]      hold_q;
  logic                        first_beat;
  logic                        last_beat;
  logic [2*`LSU_DATA_W-1:0]    merged;
  logic [2*`LSU_DATA_W-1:0]    shifted;
  logic [`LSU_DATA_W-1:0]      ext;
  logic                        result_valid_q;
  logic [`LSU_DATA_W-1:0]      result_rdata_q;

  //////////////////////////////////////////////////
  // Instruction record FIFO
  //////////////////////////////////////////////////

  assign head = fifo_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (info_push_i) begin
      fifo_q[wr_ptr_q] <= info_i;
    end
  end

  // Pointers wrap naturally because the depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (info_push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (last_beat) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Split tracking and data merge
  //////////////////////////////////////////////////

  // The lower word of a split access always answers first
  assign first_beat = bus.rvalid && head.split && !half_q;
  assign last_beat  = bus.rvalid && (!head.split || half_q);

  // Every rvalid retires one transfer on the request side
  assign resp_done_o = bus.rvalid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q <= 1'b0;
    end else if (first_beat) begin
      half_q <= 1'b1;
    end else if (last_beat) begin
      half_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (first_beat) begin
      hold_q <= bus.rdata;
    end
  end

  // Low word in the lower half, then shift the addressed byte down to lane 0
  assign merged  = head.split ? {bus.rdata, hold_q} : {{`LSU_DATA_W{1'b0}}, bus.rdata};
  assign shifted = merged >> {head.off, 3'b000};

  always_comb begin
    case (head.size)
      SIZE_BYTE: ext = {{24{head.is_signed & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: ext = {{16{head.is_signed & shifted[15]}}, shifted[15:0]};
      default:   ext = shifted[`LSU_DATA_W-1:0];
    endcase
    if (head.op == LSU_STORE) begin
      ext = '0;
    end
  end

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= last_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (last_beat) begin
      result_rdata_q <= ext;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_rdata_o = result_rdata_q;

endmodule

// ==== hw/data_sram.sv ====
// Single-port word memory on the data bus, cleared at reset.
// Address bits above the word index are ignored, so accesses wrap.
// Grants are withheld while stall_i is high.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module data_sram (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall_i,
  obi_data_if.subordinate  bus
);

  logic [`LSU_DATA_W-1:0]  mem_q [`LSU_MEM_WORDS];
  logic [`LSU_MEM_AW-1:0]  idx;
  logic                    trans;
  logic                    rvalid_q;
  logic [`LSU_DATA_W-1:0]  rdata_q;

  // Back-pressure is the only reason to refuse a request
  assign bus.gnt = !stall_i;
  assign trans   = bus.req && bus.gnt;
  assign idx     = bus.addr[`LSU_MEM_AW+1:2];

  //////////////////////////////////////////////////
  // Storage with byte enables
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (trans && bus.we) begin
      for (int b = 0; b < `LSU_DATA_W/8; b++) begin
        if (bus.be[b]) begin
          mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Response one cycle after the grant
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= trans;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk) begin
    if (trans) begin
      rdata_q <= bus.we ? '0 : mem_q[idx];
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

// ==== hw/lsu_top.sv ====
// Load/store unit with its data memory behind an OBI-style bus.
// op_i is 0 for load and 1 for store; size_i is 0 byte, 1 half, 2 word.
// result_valid_o pulses once per instruction, in issue order.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,

  // Instruction side
  input  logic                     valid_i,
  output logic                     ready_o,
  input  logic                     op_i,
  input  logic [1:0]               size_i,
  input  logic                     signed_i,
  input  logic [`LSU_DATA_W-1:0]   addr_i,
  input  logic [`LSU_DATA_W-1:0]   wdata_i,

  // Result side
  output logic                     result_valid_o,
  output logic [`LSU_DATA_W-1:0]   result_rdata_o,

  // Status and back-pressure
  output logic                     busy_o,
  input  logic                     stall_i
);

  logic       resp_done;
  logic       info_push;
  lsu_info_t  info;

  // Data bus between the LSU and the memory
  obi_data_if u_bus ();

  lsu_request u_lsu_request (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .op_i        (op_i),
    .size_i      (size_i),
    .signed_i    (signed_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .resp_done_i (resp_done),
    .busy_o      (busy_o),
    .info_push_o (info_push),
    .info_o      (info),
    .bus         (u_bus.manager)
  );

  lsu_response u_lsu_response (
    .clk            (clk),
    .rst_n          (rst_n),
    .info_push_i    (info_push),
    .info_i         (info),
    .bus            (u_bus.monitor),
    .resp_done_o    (resp_done),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o)
  );

  data_sram u_data_sram (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall_i (stall_i),
    .bus     (u_bus.subordinate)
  );

endmodule

// ==== test/lsu_assertions.sv ====
// Concurrent checks on the LSU request side, bound into lsu_request.
// All checks are off while rst_n is low.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_assertions (
  input logic                     clk,
  input logic                     rst_n,
  input logic [1:0]               cnt_i,
  input logic                     busy_i,
  input logic                     req_i,
  input logic                     gnt_i,
  input logic                     rvalid_i,
  input logic [`LSU_DATA_W-1:0]   addr_i,
  input logic                     we_i,
  input logic [`LSU_DATA_W/8-1:0] be_i,
  input logic [`LSU_DATA_W-1:0]   wdata_i
);

  // Number of failed checks, read by the testbench at the end
  int unsigned fails = 0;

  // The transfer counter stays within the outstanding limit
  cnt_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= 2'(`LSU_DEPTH))
  else begin
    fails++;
    $error("transfer count %0d above the limit", cnt_i);
  end

  // A granted transfer keeps busy high in the cycle after it
  busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i && gnt_i) |=> busy_i)
  else begin
    fails++;
    $error("busy %b after a transfer, transfer count %0d", busy_i, cnt_i);
  end

  // Every rvalid answers a transfer that the counter still holds
  rvalid_a: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (cnt_i != 2'd0))
  else begin
    fails++;
    $error("rvalid with no transfer outstanding");
  end

  // A waiting request keeps its payload until it is granted
  req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i) && $stable(we_i)
                           && $stable(be_i) && $stable(wdata_i)))
  else begin
    fails++;
    $error("request dropped or changed before its grant");
  end

endmodule

// ==== test/lsu_tb.sv ====
// Testbench for the LSU that replays instructions from test/lsu_patterns.txt.
// Each pattern holds seven hex words, listed at the top of that file.
// The memory is cleared by reset, so untouched words read back as 0.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb;

  localparam int MAX_ENTRIES = 64;
  localparam int FIELDS      = 7;
  localparam int WAIT_LIMIT  = 200;

  logic                    clk;
  logic                    rst_n;
  logic                    valid_i;
  logic                    ready_o;
  logic                    op_i;
  logic [1:0]              size_i;
  logic                    signed_i;
  logic [`LSU_DATA_W-1:0]  addr_i;
  logic [`LSU_DATA_W-1:0]  wdata_i;
  logic                    result_valid_o;
  logic [`LSU_DATA_W-1:0]  result_rdata_o;
  logic                    busy_o;
  logic                    stall_i;

  // Pattern words, FIELDS per instruction
  logic [31:0]             pat [MAX_ENTRIES*FIELDS];
  int                      n_entries;
  integer                  seed = 60663;

  int                      cyc = 0;
  int                      errors = 0;
  int                      tests = 0;
  int                      outstanding = 0;
  int                      overlapped = 0;
  logic                    checks_on = 1'b0;
  logic                    timed_out = 1'b0;

  // Expected results in issue order; a latency of 0 is not checked
  logic [`LSU_DATA_W-1:0]  exp_data_q [$];
  int                      exp_lat_q [$];
  int                      acc_cyc_q [$];
  int                      test_id_q [$];

  lsu_top u_lsu_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .op_i           (op_i),
    .size_i         (size_i),
    .signed_i       (signed_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o),
    .busy_o         (busy_o),
    .stall_i        (stall_i)
  );

  bind lsu_request lsu_assertions u_lsu_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .cnt_i    (cnt_q),
    .busy_i   (busy_o),
    .req_i    (bus.req),
    .gnt_i    (bus.gnt),
    .rvalid_i (bus.rvalid),
    .addr_i   (bus.addr),
    .we_i     (bus.we),
    .be_i     (bus.be),
    .wdata_i  (bus.wdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc       <= cyc + 1;
    checks_on <= rst_n;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Halfwords at offset 3 and unaligned words need a second bus transfer
  function automatic int expected_latency(input logic [1:0] size, input logic [1:0] off);
    if ((size == 2'd1 && off == 2'd3) || (size == 2'd2 && off != 2'd0)) begin
      return 4;
    end
    return 3;
  endfunction

  task automatic load_patterns();
    for (int i = 0; i < MAX_ENTRIES*FIELDS; i++) begin
      pat[i] = 32'hffff_0000 | 32'(i);
    end
    $readmemh("test/lsu_patterns.txt", pat);
    // The list ends at the first op word that is neither load nor store
    n_entries = 0;
    while (n_entries < MAX_ENTRIES && pat[n_entries*FIELDS] <= 32'd1) begin
      n_entries++;
    end
    $display("Loaded %0d instructions", n_entries);
  endtask

  task automatic issue_entry(input int e);
    int base;
    int idle;
    int waited;
    base = e * FIELDS;
    idle = {$random(seed)} % 4;
    repeat (idle) begin
      @(negedge clk);
      valid_i = 1'b0;
    end
    @(negedge clk);
    valid_i  = 1'b1;
    op_i     = pat[base][0];
    size_i   = pat[base+1][1:0];
    signed_i = pat[base+2][0];
    addr_i   = pat[base+3];
    wdata_i  = pat[base+4];
    waited   = 0;
    while (!ready_o && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!ready_o) begin
      $display("Timeout at %0t: instruction %0d was not accepted in %0d cycles",
               $time, e, WAIT_LIMIT);
      valid_i   = 1'b0;
      timed_out = 1'b1;
      errors++;
    end else begin
      // An issue that meets a transfer still in flight shows the pipelining
      if (outstanding != 0) begin
        overlapped++;
      end
      // Accepted at the coming rising edge
      exp_data_q.push_back(pat[base+6]);
      exp_lat_q.push_back((pat[base+5] != 0) ? 0 : expected_latency(size_i, addr_i[1:0]));
      acc_cyc_q.push_back(cyc);
      test_id_q.push_back(e);
      if (pat[base+5] != 0) begin
        // Hold off the grant of this instruction's first transfer
        @(negedge clk);
        valid_i = 1'b0;
        stall_i = 1'b1;
        repeat (pat[base+5]) @(negedge clk);
        stall_i = 1'b0;
      end
    end
  endtask

  task automatic check_result();
    logic [`LSU_DATA_W-1:0] exp;
    int                     lat;
    int                     acc;
    int                     id;
    logic                   bad;
    bad = 1'b0;
    assert (exp_data_q.size() != 0) else begin
      $display("Result at %0t arrived with no instruction pending", $time);
      errors++;
    end
    if (exp_data_q.size() != 0) begin
      exp = exp_data_q.pop_front();
      lat = exp_lat_q.pop_front();
      acc = acc_cyc_q.pop_front();
      id  = test_id_q.pop_front();
      assert (result_rdata_o == exp) else begin
        $display("[ERROR] %0t test %0d: rdata %h, expected %h", $time, id, result_rdata_o, exp);
        bad = 1'b1;
      end
      if (lat != 0) begin
        assert (cyc - acc == lat) else begin
          $display("[ERROR] %0t test %0d: result after %0d cycles, expected %0d",
                   $time, id, cyc - acc, lat);
          bad = 1'b1;
        end
      end
      tests++;
      if (bad) begin
        errors++;
      end
      $display("test %0d addr %h: %s", id, pat[id*FIELDS+3], bad ? "failed" : "ok");
    end
  endtask

  //////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////

  // Transfers granted on the bus that still wait for their rvalid
  always @(posedge clk) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding
                     + ((u_lsu_top.u_bus.req && u_lsu_top.u_bus.gnt) ? 1 : 0)
                     - (u_lsu_top.u_bus.rvalid ? 1 : 0);
    end
  end

  always @(negedge clk) begin
    if (checks_on) begin
      assert (busy_o == (outstanding != 0)) else begin
        $display("[ERROR] %0t busy_o %b with %0d transfers outstanding",
                 $time, busy_o, outstanding);
        errors++;
      end
      if (result_valid_o) begin
        check_result();
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int waited;
    rst_n    = 1'b0;
    valid_i  = 1'b0;
    op_i     = 1'b0;
    size_i   = 2'd0;
    signed_i = 1'b0;
    addr_i   = '0;
    wdata_i  = '0;
    stall_i  = 1'b0;
    load_patterns();
    repeat (8) @(negedge clk);
    // Outputs must be quiet while reset is held
    assert (!ready_o && !result_valid_o && !busy_o) else begin
      $display("[ERROR] %0t reset: ready_o %b result_valid_o %b busy_o %b, expected low",
               $time, ready_o, result_valid_o, busy_o);
      errors++;
    end
    tests++;
    $display("test reset: done");
    rst_n = 1'b1;
    for (int e = 0; e < n_entries && !timed_out; e++) begin
      issue_entry(e);
    end
    @(negedge clk);
    valid_i = 1'b0;
    waited  = 0;
    while (!timed_out && exp_data_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      $display("Timeout at %0t: %0d results never arrived", $time, exp_data_q.size());
      errors++;
    end
    // Two instructions must have shared the bus at least once
    assert (overlapped != 0) else begin
      $display("No instruction was accepted while another was still in flight");
      errors++;
    end
    tests++;
    $display("test pipelining: %0d overlapped issues", overlapped);
    repeat (2) @(negedge clk);
    errors += int'(u_lsu_top.u_lsu_request.u_lsu_assertions.fails);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== test/lsu_patterns.txt ====
// op size signed addr wdata stall_cycles expected_rdata, all hex
// op 0 load 1 store; size 0 byte 1 half 2 word; stall_cycles hold stall_i after acceptance
0 2 0 00000100 00000000 0 00000000
0 0 1 000001ff 00000000 0 00000000
1 2 0 00000010 12345678 0 00000000
0 2 0 00000010 00000000 0 12345678
1 2 0 00000020 80ff7f01 0 00000000
0 0 1 00000022 00000000 0 ffffffff
0 0 0 00000022 00000000 0 000000ff
0 0 1 00000023 00000000 0 ffffff80
0 0 1 00000021 00000000 0 0000007f
0 1 1 00000022 00000000 0 ffff80ff
0 1 0 00000022 00000000 0 000080ff
0 1 1 00000020 00000000 0 00007f01
1 0 0 00000011 000000aa 0 00000000
1 1 0 00000012 0000beef 0 00000000
0 2 0 00000010 00000000 0 beefaa78
1 2 0 00000031 a1b2c3d4 0 00000000
0 2 0 00000031 00000000 0 a1b2c3d4
0 2 0 00000030 00000000 0 b2c3d400
0 2 0 00000034 00000000 0 000000a1
1 1 0 00000043 00009abc 0 00000000
0 1 1 00000043 00000000 0 ffff9abc
0 1 0 00000043 00000000 0 00009abc
0 2 0 00000042 00000000 0 009abc00
1 2 0 00000050 cafef00d 6 00000000
0 2 0 00000050 00000000 5 cafef00d
0 2 0 00000053 00000000 4 000000ca
1 1 0 00000057 00001234 3 00000000
0 1 1 00000057 00000000 0 00001234
0 0 0 00000058 00000000 0 00000012
0 2 0 00000100 00000000 0 00000000

// ==== build.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/obi_data_if.sv
hw/lsu_request.sv
hw/lsu_response.sv
hw/data_sram.sv
hw/lsu_top.sv
test/lsu_assertions.sv
test/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= lsu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
